// ==== mgmt_pkg.sv ====
package mgmt_pkg;

	//////////////////////////////////////////////////
	// Bus widths

	localparam int APB_ADDR_W = 24;
	localparam int APB_DATA_W = 16;

	// Offset width inside one slot at each decode level
	localparam int SMOL_OFFSET_W = 10;
	localparam int BIG_OFFSET_W = 12;
	localparam int ROOT_OFFSET_W = 15;

	//////////////////////////////////////////////////
	// Address map

	// Small region: 0 sysinfo, 1 led, 2 relay
	localparam int NUM_SMOL_SLOTS = 3;

	// Large region: 0 bulk
	localparam int NUM_BIG_SLOTS = 1;

	// Fixed board ID, sysinfo offset 4
	localparam logic [APB_DATA_W-1:0] BOARD_ID = 16'h7C0B;

	// One 24-bit address seen as a small-slot or a large-slot address
	typedef union packed {
		logic [APB_ADDR_W-1:0] word;
		struct packed {
			logic [APB_ADDR_W-ROOT_OFFSET_W-2:0] upper;
			logic region;
			logic [4:0] slot;
			logic [SMOL_OFFSET_W-1:0] offset;
		} smol;
		struct packed {
			logic [APB_ADDR_W-ROOT_OFFSET_W-2:0] upper;
			logic region;
			logic [2:0] slot;
			logic [BIG_OFFSET_W-1:0] offset;
		} big;
	} mgmt_addr_t;

endpackage

// ==== fan_tach.sv ====
`timescale 1ns/100ps
module fan_tach #(
	parameter int REFCLK_HZ = 250_000_000,
	parameter int TACH_WINDOW = 25_000_000
) (
	input logic sys_clk,
	input logic arst_n,
	input logic tach,
	output logic [15:0] rpm
);

	localparam int WIN_W = $clog2(TACH_WINDOW);

	// 60 s per minute over two pulses per revolution gives 30
	// Scale by windows per second, assumed to divide evenly
	localparam longint unsigned RPM_SCALE = (64'd30 * REFCLK_HZ) / TACH_WINDOW;
	localparam logic [15:0] RPM_MUL = 16'(RPM_SCALE);

	logic [1:0] sync_q;
	logic tach_prev_q;
	logic [WIN_W-1:0] win_cnt_q;
	logic [15:0] edge_cnt_q;
	logic rise;
	logic win_end;

	// Rising edge after the two-flop synchronizer
	assign rise = sync_q[1] && !tach_prev_q;
	assign win_end = (win_cnt_q == WIN_W'(TACH_WINDOW - 1));

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			sync_q <= 2'b00;
			tach_prev_q <= 1'b0;
			win_cnt_q <= '0;
			edge_cnt_q <= '0;
			rpm <= '0;
		end else begin
			sync_q <= {sync_q[0], tach};
			tach_prev_q <= sync_q[1];

			if (win_end) begin
				win_cnt_q <= '0;
				edge_cnt_q <= '0;
				// Edge on the last cycle still belongs to this window
				rpm <= 16'((edge_cnt_q + 16'(rise)) * RPM_MUL);
			end else begin
				win_cnt_q <= win_cnt_q + 1'b1;
				if (rise) begin
					edge_cnt_q <= edge_cnt_q + 1'b1;
				end
			end
		end
	end

endmodule

// ==== apb_region_decoder.sv ====
`timescale 1ns/100ps
module apb_region_decoder import mgmt_pkg::*; #(
	parameter int NUM_PORTS = 2,
	parameter int OFFSET_W = ROOT_OFFSET_W
) (
	input logic sys_clk,
	input logic arst_n,

	// Upstream completer side
	input logic up_psel,
	input logic up_penable,
	input logic up_pwrite,
	input mgmt_addr_t up_paddr,
	input logic [APB_DATA_W-1:0] up_pwdata,
	output logic up_pready,
	output logic [APB_DATA_W-1:0] up_prdata,
	output logic up_pslverr,

	// Downstream requester side, one lane per slot
	output logic [NUM_PORTS-1:0] dn_psel,
	output logic [NUM_PORTS-1:0] dn_penable,
	output logic [NUM_PORTS-1:0] dn_pwrite,
	output logic [NUM_PORTS-1:0][OFFSET_W-1:0] dn_paddr,
	output logic [NUM_PORTS-1:0][APB_DATA_W-1:0] dn_pwdata,
	input logic [NUM_PORTS-1:0] dn_pready,
	input logic [NUM_PORTS-1:0][APB_DATA_W-1:0] dn_prdata,
	input logic [NUM_PORTS-1:0] dn_pslverr
);

	logic [4:0] slot;
	logic bad;
	logic [4:0] sel_q;
	logic err_q;

	// Pick the slot field for this level
	always_comb begin
		if (OFFSET_W == SMOL_OFFSET_W) begin
			slot = up_paddr.smol.slot;
		end else if (OFFSET_W == BIG_OFFSET_W) begin
			slot = {2'b00, up_paddr.big.slot};
		end else begin
			// Root level splits on the region bit only
			slot = {4'b0000, up_paddr.smol.region};
		end
		bad = (up_paddr.smol.upper != '0) || (int'(slot) >= NUM_PORTS);
	end

	// Request fan-out, psel only to the addressed slot
	always_comb begin
		for (int i = 0; i < NUM_PORTS; i++) begin
			dn_psel[i] = up_psel && !bad && (int'(slot) == i);
			dn_penable[i] = up_penable;
			dn_pwrite[i] = up_pwrite;
			dn_paddr[i] = up_paddr.word[OFFSET_W-1:0];
			dn_pwdata[i] = up_pwdata;
		end
	end

	// Latch target slot during setup
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			sel_q <= '0;
			err_q <= 1'b0;
		end else if (up_psel && !up_penable) begin
			sel_q <= slot;
			err_q <= bad;
		end
	end

	// Response mux; unmapped slots complete here with an error
	always_comb begin
		up_pready = up_psel && up_penable && err_q;
		up_prdata = '0;
		up_pslverr = err_q;
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (!err_q && int'(sel_q) == i) begin
				up_pready = dn_pready[i];
				up_prdata = dn_prdata[i];
				up_pslverr = dn_pslverr[i];
			end
		end
	end

endmodule

// ==== apb_reg_slice.sv ====
`timescale 1ns/100ps
module apb_reg_slice import mgmt_pkg::*; #(
	parameter int ADDR_W = APB_ADDR_W,
	parameter bit REG_REQUEST = 1'b0,
	parameter bit REG_RESPONSE = 1'b0
) (
	input logic sys_clk,
	input logic arst_n,

	input logic up_psel,
	input logic up_penable,
	input logic up_pwrite,
	input logic [ADDR_W-1:0] up_paddr,
	input logic [APB_DATA_W-1:0] up_pwdata,
	output logic up_pready,
	output logic [APB_DATA_W-1:0] up_prdata,
	output logic up_pslverr,

	output logic dn_psel,
	output logic dn_penable,
	output logic dn_pwrite,
	output logic [ADDR_W-1:0] dn_paddr,
	output logic [APB_DATA_W-1:0] dn_pwdata,
	input logic dn_pready,
	input logic [APB_DATA_W-1:0] dn_prdata,
	input logic dn_pslverr
);

	generate
		if (REG_REQUEST) begin : g_req
			//////////////////////////////////////////////////
			// Request path registered, takes priority if both set

			logic done;

			assign done = dn_psel && dn_penable && dn_pready;

			// Setup one cycle late, then access until completion
			always_ff @(posedge sys_clk or negedge arst_n) begin
				if (!arst_n) begin
					dn_psel <= 1'b0;
					dn_penable <= 1'b0;
				end else if (done) begin
					dn_psel <= 1'b0;
					dn_penable <= 1'b0;
				end else if (dn_psel) begin
					dn_penable <= 1'b1;
				end else if (up_psel && !up_penable) begin
					dn_psel <= 1'b1;
				end
			end

			// Request fields captured at upstream setup, held until done
			always_ff @(posedge sys_clk) begin
				if (!dn_psel && up_psel && !up_penable) begin
					dn_pwrite <= up_pwrite;
					dn_paddr <= up_paddr;
					dn_pwdata <= up_pwdata;
				end
			end

			assign up_pready = done;
			assign up_prdata = dn_prdata;
			assign up_pslverr = dn_pslverr;

		end else if (REG_RESPONSE) begin : g_rsp
			//////////////////////////////////////////////////
			// Response path registered

			logic done_q;

			// Mask the request while the registered response goes up
			assign dn_psel = up_psel && !done_q;
			assign dn_penable = up_penable && !done_q;
			assign dn_pwrite = up_pwrite;
			assign dn_paddr = up_paddr;
			assign dn_pwdata = up_pwdata;

			always_ff @(posedge sys_clk or negedge arst_n) begin
				if (!arst_n) begin
					done_q <= 1'b0;
					up_pslverr <= 1'b0;
				end else begin
					done_q <= dn_psel && dn_penable && dn_pready;
					up_pslverr <= dn_psel && dn_penable && dn_pready && dn_pslverr;
				end
			end

			always_ff @(posedge sys_clk) begin
				up_prdata <= dn_prdata;
			end

			assign up_pready = done_q;

		end else begin : g_thru
			// No stage, straight connection
			assign dn_psel = up_psel;
			assign dn_penable = up_penable;
			assign dn_pwrite = up_pwrite;
			assign dn_paddr = up_paddr;
			assign dn_pwdata = up_pwdata;
			assign up_pready = dn_pready;
			assign up_prdata = dn_prdata;
			assign up_pslverr = dn_pslverr;
		end
	endgenerate

endmodule

// ==== sysinfo_regs.sv ====
`timescale 1ns/100ps
module sysinfo_regs import mgmt_pkg::*; (
	input logic sys_clk,
	input logic arst_n,

	// Read-only completer, write data not taken
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [SMOL_OFFSET_W-1:0] paddr,
	output logic pready,
	output logic [APB_DATA_W-1:0] prdata,
	output logic pslverr,

	input logic [15:0] fan0_rpm,
	input logic [15:0] fan1_rpm
);

	logic [APB_DATA_W-1:0] rd_word;
	logic rd_hit;
	logic [APB_DATA_W-1:0] rdata_q;
	logic err_q;

	// Register map
	always_comb begin
		rd_hit = 1'b1;
		case (paddr)
			10'h000: rd_word = fan0_rpm;
			10'h002: rd_word = fan1_rpm;
			10'h004: rd_word = BOARD_ID;
			default: begin
				rd_word = '0;
				rd_hit = 1'b0;
			end
		endcase
	end

	// Decode at setup, answer on first access cycle
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			err_q <= 1'b0;
		end else if (psel && !penable) begin
			err_q <= pwrite || !rd_hit;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (psel && !penable) begin
			rdata_q <= rd_word;
		end
	end

	assign pready = psel && penable;
	assign prdata = rdata_q;
	assign pslverr = err_q;

endmodule

// ==== led_status_regs.sv ====
`timescale 1ns/100ps
module led_status_regs import mgmt_pkg::*; (
	input logic sys_clk,
	input logic arst_n,

	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [SMOL_OFFSET_W-1:0] paddr,
	output logic pready,
	output logic [APB_DATA_W-1:0] prdata,
	output logic pslverr,

	input logic [11:0] trig_in_led,
	input logic [11:0] trig_out_led,
	input logic [3:0] relay_state
);

	logic [11:0] in_flipped;
	logic [11:0] out_gated;
	logic [APB_DATA_W-1:0] rd_word;
	logic rd_hit;
	logic [APB_DATA_W-1:0] rdata_q;
	logic err_q;

	always_comb begin
		// Expander pinout runs MSB first
		for (int i = 0; i < 12; i++) begin
			in_flipped[i] = trig_in_led[11-i];
		end
		// Relay-driven outputs show dark
		out_gated = {trig_out_led[11:8] & ~relay_state, trig_out_led[7:0]};

		rd_hit = 1'b1;
		case (paddr)
			10'h000: rd_word = {4'h0, in_flipped};
			10'h002: rd_word = {4'h0, out_gated};
			default: begin
				rd_word = '0;
				rd_hit = 1'b0;
			end
		endcase
	end

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			err_q <= 1'b0;
		end else if (psel && !penable) begin
			err_q <= pwrite || !rd_hit;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (psel && !penable) begin
			rdata_q <= rd_word;
		end
	end

	assign pready = psel && penable;
	assign prdata = rdata_q;
	assign pslverr = err_q;

endmodule

// ==== mgmt_fabric_top.sv ====
`timescale 1ns/100ps
module mgmt_fabric_top import mgmt_pkg::*; #(
	parameter int REFCLK_HZ = 250_000_000,
	parameter int TACH_WINDOW = 25_000_000
) (
	input logic sys_clk,
	input logic arst_n,

	// Management APB from the host side
	input logic s_psel,
	input logic s_penable,
	input logic s_pwrite,
	input logic [APB_ADDR_W-1:0] s_paddr,
	input logic [APB_DATA_W-1:0] s_pwdata,
	output logic s_pready,
	output logic [APB_DATA_W-1:0] s_prdata,
	output logic s_pslverr,

	// Relay controller, small slot 2
	output logic relay_psel,
	output logic relay_penable,
	output logic relay_pwrite,
	output logic [SMOL_OFFSET_W-1:0] relay_paddr,
	output logic [APB_DATA_W-1:0] relay_pwdata,
	input logic relay_pready,
	input logic [APB_DATA_W-1:0] relay_prdata,
	input logic relay_pslverr,

	// Bulk port, large slot 0
	output logic bulk_psel,
	output logic bulk_penable,
	output logic bulk_pwrite,
	output logic [BIG_OFFSET_W-1:0] bulk_paddr,
	output logic [APB_DATA_W-1:0] bulk_pwdata,
	input logic bulk_pready,
	input logic [APB_DATA_W-1:0] bulk_prdata,
	input logic bulk_pslverr,

	input logic [1:0] fan_tach,
	input logic [11:0] trig_in_led,
	input logic [11:0] trig_out_led,
	input logic [3:0] relay_state
);

	logic [15:0] fan0_rpm, fan1_rpm;

	// Root slice to root decoder
	logic rs_psel, rs_penable, rs_pwrite, rs_pready, rs_pslverr;
	mgmt_addr_t rs_paddr;
	logic [APB_DATA_W-1:0] rs_pwdata, rs_prdata;

	// Root decoder lanes, 0 small region, 1 large region
	logic [1:0] rt_psel, rt_penable, rt_pwrite, rt_pready, rt_pslverr;
	logic [1:0][ROOT_OFFSET_W-1:0] rt_paddr;
	logic [1:0][APB_DATA_W-1:0] rt_pwdata, rt_prdata;

	// Small decoder lanes
	logic [NUM_SMOL_SLOTS-1:0] sm_psel, sm_penable, sm_pwrite, sm_pready, sm_pslverr;
	logic [NUM_SMOL_SLOTS-1:0][SMOL_OFFSET_W-1:0] sm_paddr;
	logic [NUM_SMOL_SLOTS-1:0][APB_DATA_W-1:0] sm_pwdata, sm_prdata;

	// Large decoder lanes
	logic [NUM_BIG_SLOTS-1:0] bg_psel, bg_penable, bg_pwrite, bg_pready, bg_pslverr;
	logic [NUM_BIG_SLOTS-1:0][BIG_OFFSET_W-1:0] bg_paddr;
	logic [NUM_BIG_SLOTS-1:0][APB_DATA_W-1:0] bg_pwdata, bg_prdata;

	// Internal completer buses
	logic si_psel, si_penable, si_pwrite, si_pready, si_pslverr;
	logic [SMOL_OFFSET_W-1:0] si_paddr;
	logic [APB_DATA_W-1:0] si_prdata;
	logic ld_psel, ld_penable, ld_pwrite, ld_pready, ld_pslverr;
	logic [SMOL_OFFSET_W-1:0] ld_paddr;
	logic [APB_DATA_W-1:0] ld_prdata;

	//////////////////////////////////////////////////
	// Fan tachometers

	fan_tach #(.REFCLK_HZ(REFCLK_HZ), .TACH_WINDOW(TACH_WINDOW)) tach0 (
		.sys_clk(sys_clk), .arst_n(arst_n), .tach(fan_tach[0]), .rpm(fan0_rpm));

	fan_tach #(.REFCLK_HZ(REFCLK_HZ), .TACH_WINDOW(TACH_WINDOW)) tach1 (
		.sys_clk(sys_clk), .arst_n(arst_n), .tach(fan_tach[1]), .rpm(fan1_rpm));

	//////////////////////////////////////////////////
	// Root slice and root split at 0x8000

	apb_reg_slice #(.ADDR_W(APB_ADDR_W), .REG_REQUEST(1'b0), .REG_RESPONSE(1'b1)) root_slice (
		.sys_clk(sys_clk), .arst_n(arst_n),
		.up_psel(s_psel), .up_penable(s_penable), .up_pwrite(s_pwrite),
		.up_paddr(s_paddr), .up_pwdata(s_pwdata),
		.up_pready(s_pready), .up_prdata(s_prdata), .up_pslverr(s_pslverr),
		.dn_psel(rs_psel), .dn_penable(rs_penable), .dn_pwrite(rs_pwrite),
		.dn_paddr(rs_paddr), .dn_pwdata(rs_pwdata),
		.dn_pready(rs_pready), .dn_prdata(rs_prdata), .dn_pslverr(rs_pslverr));

	apb_region_decoder #(.NUM_PORTS(2), .OFFSET_W(ROOT_OFFSET_W)) root_dec (
		.sys_clk(sys_clk), .arst_n(arst_n),
		.up_psel(rs_psel), .up_penable(rs_penable), .up_pwrite(rs_pwrite),
		.up_paddr(rs_paddr), .up_pwdata(rs_pwdata),
		.up_pready(rs_pready), .up_prdata(rs_prdata), .up_pslverr(rs_pslverr),
		.dn_psel(rt_psel), .dn_penable(rt_penable), .dn_pwrite(rt_pwrite),
		.dn_paddr(rt_paddr), .dn_pwdata(rt_pwdata),
		.dn_pready(rt_pready), .dn_prdata(rt_prdata), .dn_pslverr(rt_pslverr));

	//////////////////////////////////////////////////
	// Second level, 1 KB and 4 KB slots

	apb_region_decoder #(.NUM_PORTS(NUM_SMOL_SLOTS), .OFFSET_W(SMOL_OFFSET_W)) smol_dec (
		.sys_clk(sys_clk), .arst_n(arst_n),
		.up_psel(rt_psel[0]), .up_penable(rt_penable[0]), .up_pwrite(rt_pwrite[0]),
		.up_paddr(mgmt_addr_t'({9'd0, rt_paddr[0]})), .up_pwdata(rt_pwdata[0]),
		.up_pready(rt_pready[0]), .up_prdata(rt_prdata[0]), .up_pslverr(rt_pslverr[0]),
		.dn_psel(sm_psel), .dn_penable(sm_penable), .dn_pwrite(sm_pwrite),
		.dn_paddr(sm_paddr), .dn_pwdata(sm_pwdata),
		.dn_pready(sm_pready), .dn_prdata(sm_prdata), .dn_pslverr(sm_pslverr));

	apb_region_decoder #(.NUM_PORTS(NUM_BIG_SLOTS), .OFFSET_W(BIG_OFFSET_W)) big_dec (
		.sys_clk(sys_clk), .arst_n(arst_n),
		.up_psel(rt_psel[1]), .up_penable(rt_penable[1]), .up_pwrite(rt_pwrite[1]),
		.up_paddr(mgmt_addr_t'({9'd0, rt_paddr[1]})), .up_pwdata(rt_pwdata[1]),
		.up_pready(rt_pready[1]), .up_prdata(rt_prdata[1]), .up_pslverr(rt_pslverr[1]),
		.dn_psel(bg_psel), .dn_penable(bg_penable), .dn_pwrite(bg_pwrite),
		.dn_paddr(bg_paddr), .dn_pwdata(bg_pwdata),
		.dn_pready(bg_pready), .dn_prdata(bg_prdata), .dn_pslverr(bg_pslverr));

	//////////////////////////////////////////////////
	// Slot slices and completers

	// Sysinfo at 0x00_0000
	apb_reg_slice #(.ADDR_W(SMOL_OFFSET_W), .REG_REQUEST(1'b1), .REG_RESPONSE(1'b0)) sysinfo_slice (
		.sys_clk(sys_clk), .arst_n(arst_n),
		.up_psel(sm_psel[0]), .up_penable(sm_penable[0]), .up_pwrite(sm_pwrite[0]),
		.up_paddr(sm_paddr[0]), .up_pwdata(sm_pwdata[0]),
		.up_pready(sm_pready[0]), .up_prdata(sm_prdata[0]), .up_pslverr(sm_pslverr[0]),
		.dn_psel(si_psel), .dn_penable(si_penable), .dn_pwrite(si_pwrite),
		.dn_paddr(si_paddr), .dn_pwdata(),
		.dn_pready(si_pready), .dn_prdata(si_prdata), .dn_pslverr(si_pslverr));

	sysinfo_regs sysinfo (
		.sys_clk(sys_clk), .arst_n(arst_n),
		.psel(si_psel), .penable(si_penable), .pwrite(si_pwrite), .paddr(si_paddr),
		.pready(si_pready), .prdata(si_prdata), .pslverr(si_pslverr),
		.fan0_rpm(fan0_rpm), .fan1_rpm(fan1_rpm));

	// LED status at 0x00_0400
	apb_reg_slice #(.ADDR_W(SMOL_OFFSET_W), .REG_REQUEST(1'b1), .REG_RESPONSE(1'b0)) led_slice (
		.sys_clk(sys_clk), .arst_n(arst_n),
		.up_psel(sm_psel[1]), .up_penable(sm_penable[1]), .up_pwrite(sm_pwrite[1]),
		.up_paddr(sm_paddr[1]), .up_pwdata(sm_pwdata[1]),
		.up_pready(sm_pready[1]), .up_prdata(sm_prdata[1]), .up_pslverr(sm_pslverr[1]),
		.dn_psel(ld_psel), .dn_penable(ld_penable), .dn_pwrite(ld_pwrite),
		.dn_paddr(ld_paddr), .dn_pwdata(),
		.dn_pready(ld_pready), .dn_prdata(ld_prdata), .dn_pslverr(ld_pslverr));

	led_status_regs led_status (
		.sys_clk(sys_clk), .arst_n(arst_n),
		.psel(ld_psel), .penable(ld_penable), .pwrite(ld_pwrite), .paddr(ld_paddr),
		.pready(ld_pready), .prdata(ld_prdata), .pslverr(ld_pslverr),
		.trig_in_led(trig_in_led), .trig_out_led(trig_out_led), .relay_state(relay_state));

	// Relay controller at 0x00_0800
	apb_reg_slice #(.ADDR_W(SMOL_OFFSET_W), .REG_REQUEST(1'b1), .REG_RESPONSE(1'b0)) relay_slice (
		.sys_clk(sys_clk), .arst_n(arst_n),
		.up_psel(sm_psel[2]), .up_penable(sm_penable[2]), .up_pwrite(sm_pwrite[2]),
		.up_paddr(sm_paddr[2]), .up_pwdata(sm_pwdata[2]),
		.up_pready(sm_pready[2]), .up_prdata(sm_prdata[2]), .up_pslverr(sm_pslverr[2]),
		.dn_psel(relay_psel), .dn_penable(relay_penable), .dn_pwrite(relay_pwrite),
		.dn_paddr(relay_paddr), .dn_pwdata(relay_pwdata),
		.dn_pready(relay_pready), .dn_prdata(relay_prdata), .dn_pslverr(relay_pslverr));

	// Bulk port at 0x00_8000
	apb_reg_slice #(.ADDR_W(BIG_OFFSET_W), .REG_REQUEST(1'b1), .REG_RESPONSE(1'b0)) bulk_slice (
		.sys_clk(sys_clk), .arst_n(arst_n),
		.up_psel(bg_psel[0]), .up_penable(bg_penable[0]), .up_pwrite(bg_pwrite[0]),
		.up_paddr(bg_paddr[0]), .up_pwdata(bg_pwdata[0]),
		.up_pready(bg_pready[0]), .up_prdata(bg_prdata[0]), .up_pslverr(bg_pslverr[0]),
		.dn_psel(bulk_psel), .dn_penable(bulk_penable), .dn_pwrite(bulk_pwrite),
		.dn_paddr(bulk_paddr), .dn_pwdata(bulk_pwdata),
		.dn_pready(bulk_pready), .dn_prdata(bulk_prdata), .dn_pslverr(bulk_pslverr));

endmodule

// ==== mgmt_properties.sv ====
`timescale 1ns/100ps
module mgmt_properties import mgmt_pkg::*; (
	input logic sys_clk,
	input logic arst_n,
	input logic relay_psel,
	input logic relay_penable,
	input logic relay_pwrite,
	input logic [SMOL_OFFSET_W-1:0] relay_paddr,
	input logic [APB_DATA_W-1:0] relay_pwdata,
	input logic relay_pready,
	input logic bulk_psel,
	input logic bulk_penable,
	input logic bulk_pwrite,
	input logic [BIG_OFFSET_W-1:0] bulk_paddr,
	input logic [APB_DATA_W-1:0] bulk_pwdata,
	input logic bulk_pready
);

	int fail_cnt = 0;

	//////////////////////////////////////////////////
	// External request held while a transfer waits

	assert property (@(posedge sys_clk) disable iff (!arst_n)
		relay_psel && relay_penable && !relay_pready |=>
		relay_psel && $stable(relay_paddr) && $stable(relay_pwrite) && $stable(relay_pwdata))
	else begin
		$error("relay request changed during wait");
		fail_cnt++;
	end

	assert property (@(posedge sys_clk) disable iff (!arst_n)
		bulk_psel && bulk_penable && !bulk_pready |=>
		bulk_psel && $stable(bulk_paddr) && $stable(bulk_pwrite) && $stable(bulk_pwdata))
	else begin
		$error("bulk request changed during wait");
		fail_cnt++;
	end

	//////////////////////////////////////////////////
	// Setup followed by access and only one port selected at a time

	assert property (@(posedge sys_clk) disable iff (!arst_n)
		relay_psel && !relay_penable |=> relay_psel && relay_penable)
	else begin
		$error("relay setup not followed by access");
		fail_cnt++;
	end

	assert property (@(posedge sys_clk) disable iff (!arst_n)
		bulk_psel && !bulk_penable |=> bulk_psel && bulk_penable)
	else begin
		$error("bulk setup not followed by access");
		fail_cnt++;
	end

	assert property (@(posedge sys_clk) disable iff (!arst_n) !(relay_psel && bulk_psel))
	else begin
		$error("relay and bulk selected together");
		fail_cnt++;
	end

endmodule

bind mgmt_fabric_top mgmt_properties props (.*);

// ==== mgmt_checker.sv ====
`timescale 1ns/100ps
module mgmt_checker import mgmt_pkg::*; (
	input logic sys_clk,
	input logic arst_n,

	// Host side response
	input logic s_pready,
	input logic [APB_DATA_W-1:0] s_prdata,
	input logic s_pslverr,

	// External request activity
	input logic relay_psel,
	input logic relay_penable,
	input logic relay_pwrite,
	input logic bulk_psel,
	input logic bulk_penable,
	input logic bulk_pwrite,

	// Last write taken by each external model
	input logic [SMOL_OFFSET_W-1:0] relay_wr_addr,
	input logic [APB_DATA_W-1:0] relay_wr_data,
	input logic [BIG_OFFSET_W-1:0] bulk_wr_addr,
	input logic [APB_DATA_W-1:0] bulk_wr_data,

	// Current table row
	input int row_idx,
	input logic exp_write,
	input logic [APB_DATA_W-1:0] exp_wdata,
	input logic [APB_DATA_W-1:0] exp_rdata,
	input logic exp_err,
	input logic [1:0] exp_port,
	input logic [BIG_OFFSET_W-1:0] exp_ext,

	output int data_errs,
	output int flag_errs,
	output int route_errs
);

	// Setup cycles seen per external port since last completion
	int relay_hits;
	int bulk_hits;

	always @(posedge sys_clk) begin
		if (!arst_n) begin
			data_errs = 0;
			flag_errs = 0;
			route_errs = 0;
			relay_hits = 0;
			bulk_hits = 0;
		end else begin
			if (s_pready) begin
				if (s_pslverr !== exp_err) begin
					flag_errs++;
					$display("ERR %0t: row %0d pslverr %b, expected %b",
						$time, row_idx, s_pslverr, exp_err);
				end
				// Read data only counts on a good read
				if (!exp_err && !exp_write && s_prdata !== exp_rdata) begin
					data_errs++;
					$display("ERR %0t: row %0d read %h, expected %h",
						$time, row_idx, s_prdata, exp_rdata);
				end
				// Port 1 relay, port 2 bulk, 0 neither
				if (relay_hits != ((exp_port == 2'd1) ? 1 : 0) ||
						bulk_hits != ((exp_port == 2'd2) ? 1 : 0)) begin
					route_errs++;
					$display("ERR %0t: row %0d reached relay %0d, bulk %0d times, port %0d",
						$time, row_idx, relay_hits, bulk_hits, exp_port);
				end
				if (exp_write && exp_port == 2'd1 &&
						(relay_wr_addr !== exp_ext[SMOL_OFFSET_W-1:0] ||
						relay_wr_data !== exp_wdata)) begin
					data_errs++;
					$display("ERR %0t: row %0d relay write %h=%h, expected %h=%h",
						$time, row_idx, relay_wr_addr, relay_wr_data, exp_ext, exp_wdata);
				end
				if (exp_write && exp_port == 2'd2 &&
						(bulk_wr_addr !== exp_ext || bulk_wr_data !== exp_wdata)) begin
					data_errs++;
					$display("ERR %0t: row %0d bulk write %h=%h, expected %h=%h",
						$time, row_idx, bulk_wr_addr, bulk_wr_data, exp_ext, exp_wdata);
				end
				relay_hits = 0;
				bulk_hits = 0;
			end
			// Direction seen at each external setup
			if (relay_psel && !relay_penable) begin
				relay_hits++;
				if (relay_pwrite !== exp_write) begin
					data_errs++;
					$display("ERR %0t: row %0d relay pwrite %b, expected %b",
						$time, row_idx, relay_pwrite, exp_write);
				end
			end
			if (bulk_psel && !bulk_penable) begin
				bulk_hits++;
				if (bulk_pwrite !== exp_write) begin
					data_errs++;
					$display("ERR %0t: row %0d bulk pwrite %b, expected %b",
						$time, row_idx, bulk_pwrite, exp_write);
				end
			end
		end
	end

endmodule

// ==== tb_mgmt_top.sv ====
`timescale 1ns/100ps
// External APB completer with random wait states
module apb_completer_model #(
	parameter int ADDR_W = 10,
	parameter logic [15:0] READ_BASE = 16'hA000
) (
	input logic sys_clk,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [ADDR_W-1:0] paddr,
	input logic [15:0] pwdata,
	output logic pready,
	output logic [15:0] prdata,
	output logic [ADDR_W-1:0] wr_addr,
	output logic [15:0] wr_data
);

	logic rdy = 1'b0;
	logic [15:0] rdata = 16'h0000;
	logic [ADDR_W-1:0] log_addr = '0;
	logic [15:0] log_data = 16'h0000;
	int wait_left = 0;

	assign pready = rdy;
	assign prdata = rdata;
	assign wr_addr = log_addr;
	assign wr_data = log_data;

	always @(posedge sys_clk) begin
		if (rdy) begin
			// Transfer completes on this edge
			rdy <= 1'b0;
			if (pwrite) begin
				log_addr <= paddr;
				log_data <= pwdata;
			end
		end else if (psel && !penable) begin
			// Setup, pick 0 to 3 wait cycles
			wait_left = int'($urandom_range(3, 0));
			if (wait_left == 0) begin
				rdy <= 1'b1;
				rdata <= READ_BASE + 16'(paddr);
			end
		end else if (psel && penable) begin
			wait_left = wait_left - 1;
			if (wait_left == 0) begin
				rdy <= 1'b1;
				rdata <= READ_BASE + 16'(paddr);
			end
		end
	end

endmodule

module tb_mgmt_top import mgmt_pkg::*; ();

	// Small numbers so the RPM result is an integer
	localparam int REFCLK_HZ = 1000;
	localparam int TACH_WINDOW = 100;
	localparam int TACH0_PERIOD = 20;
	localparam int TACH1_PERIOD = 50;
	localparam int RESET_CYCLES = 8;
	localparam int WARMUP_CYCLES = 3 * TACH_WINDOW;
	localparam int NUM_ROWS = 18;

	// Row target port
	localparam logic [1:0] TO_NONE = 2'd0;
	localparam logic [1:0] TO_RELAY = 2'd1;
	localparam logic [1:0] TO_BULK = 2'd2;

	logic sys_clk = 1'b0;
	logic arst_n;
	logic s_psel;
	logic s_penable;
	logic s_pwrite;
	logic [APB_ADDR_W-1:0] s_paddr;
	logic [APB_DATA_W-1:0] s_pwdata;
	logic s_pready;
	logic [APB_DATA_W-1:0] s_prdata;
	logic s_pslverr;
	logic relay_psel;
	logic relay_penable;
	logic relay_pwrite;
	logic [SMOL_OFFSET_W-1:0] relay_paddr;
	logic [APB_DATA_W-1:0] relay_pwdata;
	logic relay_pready;
	logic [APB_DATA_W-1:0] relay_prdata;
	logic relay_pslverr;
	logic bulk_psel;
	logic bulk_penable;
	logic bulk_pwrite;
	logic [BIG_OFFSET_W-1:0] bulk_paddr;
	logic [APB_DATA_W-1:0] bulk_pwdata;
	logic bulk_pready;
	logic [APB_DATA_W-1:0] bulk_prdata;
	logic bulk_pslverr;
	logic [1:0] fan_tach = 2'b00;
	logic [11:0] trig_in_led;
	logic [11:0] trig_out_led;
	logic [3:0] relay_state;

	// Model write logs
	logic [SMOL_OFFSET_W-1:0] relay_wr_addr;
	logic [APB_DATA_W-1:0] relay_wr_data;
	logic [BIG_OFFSET_W-1:0] bulk_wr_addr;
	logic [APB_DATA_W-1:0] bulk_wr_data;

	// Stimulus table, one entry per transfer
	logic row_wr [NUM_ROWS];
	logic [APB_ADDR_W-1:0] row_addr [NUM_ROWS];
	logic [APB_DATA_W-1:0] row_wdata [NUM_ROWS];
	logic [APB_DATA_W-1:0] row_rdata [NUM_ROWS];
	logic row_err [NUM_ROWS];
	logic [1:0] row_port [NUM_ROWS];
	logic [BIG_OFFSET_W-1:0] row_ext [NUM_ROWS];
	int n_rows = 0;

	// Row under test, seen by the checker
	int row_idx;
	logic exp_write;
	logic [APB_DATA_W-1:0] exp_wdata;
	logic [APB_DATA_W-1:0] exp_rdata;
	logic exp_err;
	logic [1:0] exp_port;
	logic [BIG_OFFSET_W-1:0] exp_ext;

	int data_errs;
	int flag_errs;
	int route_errs;
	int int_phase0 = 0;
	int int_phase1 = 0;

	always #4 sys_clk = ~sys_clk;

	mgmt_fabric_top #(.REFCLK_HZ(REFCLK_HZ), .TACH_WINDOW(TACH_WINDOW)) UUT (.*);

	apb_completer_model #(.ADDR_W(SMOL_OFFSET_W), .READ_BASE(16'hA000)) relay_model (
		.sys_clk(sys_clk), .psel(relay_psel), .penable(relay_penable),
		.pwrite(relay_pwrite), .paddr(relay_paddr), .pwdata(relay_pwdata),
		.pready(relay_pready), .prdata(relay_prdata),
		.wr_addr(relay_wr_addr), .wr_data(relay_wr_data));

	apb_completer_model #(.ADDR_W(BIG_OFFSET_W), .READ_BASE(16'hB000)) bulk_model (
		.sys_clk(sys_clk), .psel(bulk_psel), .penable(bulk_penable),
		.pwrite(bulk_pwrite), .paddr(bulk_paddr), .pwdata(bulk_pwdata),
		.pready(bulk_pready), .prdata(bulk_prdata),
		.wr_addr(bulk_wr_addr), .wr_data(bulk_wr_data));

	mgmt_checker check (.*);

	//////////////////////////////////////////////////
	// Fan tach sources, two fixed rates

	always @(posedge sys_clk) begin
		int_phase0 <= (int_phase0 == TACH0_PERIOD - 1) ? 0 : int_phase0 + 1;
		int_phase1 <= (int_phase1 == TACH1_PERIOD - 1) ? 0 : int_phase1 + 1;
		fan_tach <= {int_phase1 < TACH1_PERIOD / 2, int_phase0 < TACH0_PERIOD / 2};
	end

	// Two pulses per revolution, edges counted over one window
	function automatic logic [15:0] expected_rpm(int period);
		int edges;
		edges = TACH_WINDOW / period;
		return 16'(edges * 30 * REFCLK_HZ / TACH_WINDOW);
	endfunction

	// Expander wants the input LEDs MSB first
	function automatic logic [15:0] reversed_leds(logic [11:0] leds);
		logic [15:0] r;
		r = 16'h0000;
		for (int i = 0; i < 12; i++) begin
			r[11 - i] = leds[i];
		end
		return r;
	endfunction

	// Relay-driven output LEDs read as off
	function automatic logic [15:0] masked_leds(logic [11:0] leds, logic [3:0] relays);
		logic [15:0] r;
		r = {4'h0, leds};
		for (int i = 0; i < 4; i++) begin
			if (relays[i]) begin
				r[8 + i] = 1'b0;
			end
		end
		return r;
	endfunction

	function automatic mgmt_addr_t smol_addr(int slot, logic [SMOL_OFFSET_W-1:0] off);
		mgmt_addr_t a;
		a.word = '0;
		a.smol.slot = 5'(slot);
		a.smol.offset = off;
		return a;
	endfunction

	function automatic mgmt_addr_t big_addr(int slot, logic [BIG_OFFSET_W-1:0] off);
		mgmt_addr_t a;
		a.word = '0;
		a.big.region = 1'b1;
		a.big.slot = 3'(slot);
		a.big.offset = off;
		return a;
	endfunction

	task automatic add_row(input logic wr, input mgmt_addr_t a, input logic [15:0] wdata,
			input logic [15:0] rdata, input logic err, input logic [1:0] port);
		row_wr[n_rows] = wr;
		row_addr[n_rows] = a.word;
		row_wdata[n_rows] = wdata;
		row_rdata[n_rows] = rdata;
		row_err[n_rows] = err;
		row_port[n_rows] = port;
		// Offset as the external port should see it
		row_ext[n_rows] = (port == TO_BULK) ? a.big.offset : 12'(a.smol.offset);
		n_rows++;
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		logic [11:0] in_val;
		logic [11:0] out_val;
		logic [3:0] relay_val;
		logic [SMOL_OFFSET_W-1:0] relay_off;
		logic [BIG_OFFSET_W-1:0] bulk_off;
		mgmt_addr_t high_addr;
		void'($urandom(32'h9e6c));
		arst_n = 1'b0;
		s_psel = 1'b0;
		s_penable = 1'b0;
		s_pwrite = 1'b0;
		s_paddr = '0;
		s_pwdata = '0;
		relay_pslverr = 1'b0;
		bulk_pslverr = 1'b0;
		trig_in_led = 12'h000;
		trig_out_led = 12'h000;
		relay_state = 4'h0;
		row_idx = 0;
		exp_write = 1'b0;
		exp_wdata = '0;
		exp_rdata = '0;
		exp_err = 1'b0;
		exp_port = TO_NONE;
		exp_ext = '0;

		in_val = 12'($urandom);
		// Upper outputs lit so the relay mask shows
		out_val = 12'($urandom) | 12'hF00;
		relay_val = 4'($urandom);
		relay_off = 10'($urandom);
		bulk_off = 12'($urandom);
		high_addr.word = 24'h01_0800;

		// Sysinfo and LED reads
		add_row(1'b0, smol_addr(0, 10'h004), 16'h0, 16'h7C0B, 1'b0, TO_NONE);
		add_row(1'b0, smol_addr(0, 10'h000), 16'h0, expected_rpm(TACH0_PERIOD), 1'b0, TO_NONE);
		add_row(1'b0, smol_addr(0, 10'h002), 16'h0, expected_rpm(TACH1_PERIOD), 1'b0, TO_NONE);
		add_row(1'b0, smol_addr(1, 10'h000), 16'h0, reversed_leds(in_val), 1'b0, TO_NONE);
		add_row(1'b0, smol_addr(1, 10'h002), 16'h0, masked_leds(out_val, relay_val), 1'b0,
			TO_NONE);
		// Relay controller in small slot 2
		add_row(1'b1, smol_addr(2, 10'h010), 16'h1234, 16'h0, 1'b0, TO_RELAY);
		add_row(1'b0, smol_addr(2, 10'h3FE), 16'h0, 16'hA3FE, 1'b0, TO_RELAY);
		add_row(1'b1, smol_addr(2, 10'h2A0), 16'($urandom), 16'h0, 1'b0, TO_RELAY);
		add_row(1'b0, smol_addr(2, relay_off), 16'h0, 16'hA000 + 16'(relay_off), 1'b0,
			TO_RELAY);
		// Bulk port in large slot 0
		add_row(1'b1, big_addr(0, 12'h000), 16'hBEEF, 16'h0, 1'b0, TO_BULK);
		add_row(1'b0, big_addr(0, 12'hFFE), 16'h0, 16'hBFFE, 1'b0, TO_BULK);
		add_row(1'b1, big_addr(0, 12'h7C4), 16'($urandom), 16'h0, 1'b0, TO_BULK);
		add_row(1'b0, big_addr(0, bulk_off), 16'h0, 16'hB000 + 16'(bulk_off), 1'b0, TO_BULK);
		// Unmapped slots, high address bits, write to read-only block
		add_row(1'b0, smol_addr(5, 10'h000), 16'h0, 16'h0, 1'b1, TO_NONE);
		add_row(1'b1, big_addr(1, 12'h010), 16'h5A5A, 16'h0, 1'b1, TO_NONE);
		add_row(1'b0, high_addr, 16'h0, 16'h0, 1'b1, TO_NONE);
		add_row(1'b1, smol_addr(0, 10'h004), 16'hFFFF, 16'h0, 1'b1, TO_NONE);
		// Fabric still good after errors
		add_row(1'b0, smol_addr(1, 10'h002), 16'h0, masked_leds(out_val, relay_val), 1'b0,
			TO_NONE);

		repeat (RESET_CYCLES) @(posedge sys_clk);
		arst_n <= 1'b1;
		trig_in_led <= in_val;
		trig_out_led <= out_val;
		relay_state <= relay_val;

		// Let both tachs settle over full windows
		repeat (WARMUP_CYCLES) @(posedge sys_clk);

		for (int r = 0; r < n_rows; r++) begin
			@(posedge sys_clk);
			row_idx <= r;
			exp_write <= row_wr[r];
			exp_wdata <= row_wdata[r];
			exp_rdata <= row_rdata[r];
			exp_err <= row_err[r];
			exp_port <= row_port[r];
			exp_ext <= row_ext[r];
			s_psel <= 1'b1;
			s_penable <= 1'b0;
			s_pwrite <= row_wr[r];
			s_paddr <= row_addr[r];
			s_pwdata <= row_wdata[r];
			@(posedge sys_clk);
			s_penable <= 1'b1;
			// Access until the fabric answers
			@(posedge sys_clk);
			while (!s_pready) begin
				@(posedge sys_clk);
			end
			s_psel <= 1'b0;
			s_penable <= 1'b0;
		end

		repeat (4) @(posedge sys_clk);
		$display("Errors: data %0d, flag %0d, routing %0d, assertion %0d",
			data_errs, flag_errs, route_errs, UUT.props.fail_cnt);
		if (data_errs + flag_errs + route_errs + UUT.props.fail_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// Watchdog, 20 cycles per row on top of reset and warm-up
	initial begin
		repeat (RESET_CYCLES + WARMUP_CYCLES + NUM_ROWS * 20) @(posedge sys_clk);
		$display("Timeout: the transfers did not all complete in time");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== tb.f ====
mgmt_pkg.sv
fan_tach.sv
apb_region_decoder.sv
apb_reg_slice.sv
sysinfo_regs.sv
led_status_regs.sv
mgmt_fabric_top.sv
mgmt_properties.sv
mgmt_checker.sv
tb_mgmt_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_mgmt_top
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIM_ARGS ?= +verilator+error+limit+1000
PASS_MSG ?= === PASS ===

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
